/* cpu_config.svh */
/*
 * cpu configuration: word and index widths, memory sizes,
 * and the opcode and funct codes of the supported instructions
 */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_DATA_W       32
`define CPU_REG_ADDR_W   5
`define CPU_IMEM_ADDR_W  9
`define CPU_DMEM_ADDR_W  10

`define CPU_OP_RTYPE     6'd0
`define CPU_OP_ADDI      6'd8
`define CPU_OP_LW        6'd35
`define CPU_OP_SW        6'd43

`define CPU_FN_ADD       6'd32
`define CPU_FN_SUB       6'd34
`define CPU_FN_AND       6'd36
`define CPU_FN_OR        6'd37
`define CPU_FN_SLT       6'd42

`endif

/* cpu_pkg.sv */
/*
 * cpu package: vector types shared by the pipeline stages
 * and the alu operation codes
 */
`include "cpu_config.svh"

package cpu_pkg;

   // data or byte address word
   typedef logic [`CPU_DATA_W-1:0] word_t;

   // register index
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

   // instruction fields
   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;

   // alu operation select
   typedef logic [3:0] alu_ctrl_t;

   // classic mips alu control encoding
   parameter alu_ctrl_t ALU_AND = 4'd0;
   parameter alu_ctrl_t ALU_OR  = 4'd1;
   parameter alu_ctrl_t ALU_ADD = 4'd2;
   parameter alu_ctrl_t ALU_SUB = 4'd6;
   parameter alu_ctrl_t ALU_SLT = 4'd7;

endpackage

/* fetch_stage.sv */
/*
 * fetch stage: program counter, instruction memory with an
 * external load and readback port, and the IF/ID register
 */
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           enable,
   input  logic           stall,
   output cpu_pkg::word_t instr,
   input  cpu_pkg::word_t addr_ext,
   input  logic           wen_ext,
   input  logic           ren_ext,
   input  cpu_pkg::word_t wdata_ext,
   output cpu_pkg::word_t rdata_ext
);

   cpu_pkg::word_t               imem [0:(1 << `CPU_IMEM_ADDR_W) - 1];
   cpu_pkg::word_t               pc;
   cpu_pkg::word_t               fetched;
   logic [`CPU_IMEM_ADDR_W-1:0]  pc_idx;
   logic [`CPU_IMEM_ADDR_W-1:0]  ext_idx;
   logic                         advance;

   // word index from the byte address, low two bits dropped
   assign pc_idx  = pc[`CPU_IMEM_ADDR_W+1:2];
   assign ext_idx = addr_ext[`CPU_IMEM_ADDR_W+1:2];
   assign fetched = imem[pc_idx];
   assign advance = enable & ~stall;

   // pc steps by one word and wraps inside the instruction memory
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc    <= '0;
         instr <= '0;
      end else if (advance) begin
         pc    <= cpu_pkg::word_t'({pc_idx + 1'b1, 2'b00});
         instr <= fetched;
      end
   end

   // external port for program load and readback
   always_ff @(posedge clk) begin
      if (wen_ext) begin
         imem[ext_idx] <= wdata_ext;
      end
      if (ren_ext) begin
         rdata_ext <= imem[ext_idx];
      end
   end

endmodule

/* decode_stage.sv */
/*
 * decode stage: control and alu control decode, immediate sign
 * extension, load-use hazard detection and the ID/EX register
 */
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                enable,
   input  cpu_pkg::word_t      instr,
   input  cpu_pkg::word_t      rdata_1,
   input  cpu_pkg::word_t      rdata_2,
   output cpu_pkg::reg_addr_t  raddr_1,
   output cpu_pkg::reg_addr_t  raddr_2,
   output logic                stall,
   output cpu_pkg::word_t      ex_op_a,
   output cpu_pkg::word_t      ex_op_b,
   output cpu_pkg::word_t      ex_imm,
   output cpu_pkg::alu_ctrl_t  ex_alu_ctrl,
   output cpu_pkg::reg_addr_t  ex_rs,
   output cpu_pkg::reg_addr_t  ex_rt,
   output cpu_pkg::reg_addr_t  ex_dest,
   output logic                ex_alu_src,
   output logic                ex_reg_write,
   output logic                ex_mem_read,
   output logic                ex_mem_write,
   output logic                ex_mem_to_reg
);

   cpu_pkg::opcode_t    opcode;
   cpu_pkg::funct_t     funct;
   cpu_pkg::reg_addr_t  rs;
   cpu_pkg::reg_addr_t  rt;
   cpu_pkg::reg_addr_t  rd;
   cpu_pkg::reg_addr_t  dest;
   cpu_pkg::word_t      imm;
   cpu_pkg::alu_ctrl_t  alu_ctrl;
   logic                alu_src;
   logic                reg_write;
   logic                mem_read;
   logic                mem_write;
   logic                mem_to_reg;

   assign opcode  = instr[31:26];
   assign rs      = instr[25:21];
   assign rt      = instr[20:16];
   assign rd      = instr[15:11];
   assign funct   = instr[5:0];
   assign imm     = {{(`CPU_DATA_W-16){instr[15]}}, instr[15:0]};
   assign raddr_1 = rs;
   assign raddr_2 = rt;

   always_comb begin
      alu_ctrl   = cpu_pkg::ALU_ADD;
      dest       = rt;
      alu_src    = 1'b0;
      reg_write  = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      case (opcode)
         `CPU_OP_RTYPE: begin
            dest      = rd;
            reg_write = 1'b1;
            case (funct)
               `CPU_FN_ADD: alu_ctrl = cpu_pkg::ALU_ADD;
               `CPU_FN_SUB: alu_ctrl = cpu_pkg::ALU_SUB;
               `CPU_FN_AND: alu_ctrl = cpu_pkg::ALU_AND;
               `CPU_FN_OR:  alu_ctrl = cpu_pkg::ALU_OR;
               `CPU_FN_SLT: alu_ctrl = cpu_pkg::ALU_SLT;
               // unknown funct, including the all-zero nop, writes nothing
               default:     reg_write = 1'b0;
            endcase
         end
         `CPU_OP_ADDI: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         `CPU_OP_LW: begin
            alu_src    = 1'b1;
            reg_write  = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
         end
         `CPU_OP_SW: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
         end
         default: ;
      endcase
   end

   // load in ID/EX whose target is a source of the instruction in IF/ID
   assign stall = ex_mem_read & ((ex_dest == rs) | (ex_dest == rt));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_op_a       <= '0;
         ex_op_b       <= '0;
         ex_imm        <= '0;
         ex_alu_ctrl   <= '0;
         ex_rs         <= '0;
         ex_rt         <= '0;
         ex_dest       <= '0;
         ex_alu_src    <= 1'b0;
         ex_reg_write  <= 1'b0;
         ex_mem_read   <= 1'b0;
         ex_mem_write  <= 1'b0;
         ex_mem_to_reg <= 1'b0;
      end else if (enable) begin
         ex_op_a       <= rdata_1;
         ex_op_b       <= rdata_2;
         ex_imm        <= imm;
         ex_alu_ctrl   <= alu_ctrl;
         ex_rs         <= rs;
         ex_rt         <= rt;
         ex_dest       <= dest;
         ex_alu_src    <= alu_src;
         // bubble on a stall
         ex_reg_write  <= reg_write & ~stall;
         ex_mem_read   <= mem_read & ~stall;
         ex_mem_write  <= mem_write & ~stall;
         ex_mem_to_reg <= mem_to_reg & ~stall;
      end
   end

endmodule

/* register_file.sv */
/*
 * register file: 32 words, two read ports and one write port,
 * r0 reads zero and a same-cycle write is seen by the reads
 */
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file (
   input  logic                clk,
   input  logic                arst_n,
   input  cpu_pkg::reg_addr_t  raddr_1,
   input  cpu_pkg::reg_addr_t  raddr_2,
   output cpu_pkg::word_t      rdata_1,
   output cpu_pkg::word_t      rdata_2,
   input  logic                wb_write,
   input  cpu_pkg::reg_addr_t  wb_addr,
   input  cpu_pkg::word_t      wb_data
);

   cpu_pkg::word_t  regs [0:(1 << `CPU_REG_ADDR_W) - 1];
   logic            wr_en;

   assign wr_en = wb_write & (wb_addr != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < (1 << `CPU_REG_ADDR_W); i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // write-through so decode sees the value written back this cycle
   assign rdata_1 = (raddr_1 == '0)                 ? '0      :
                    (wr_en && (wb_addr == raddr_1)) ? wb_data : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0)                 ? '0      :
                    (wr_en && (wb_addr == raddr_2)) ? wb_data : regs[raddr_2];

endmodule

/* execute_stage.sv */
/*
 * execute stage: operand forwarding from EX/MEM and MEM/WB,
 * the alu and the EX/MEM register
 */
`timescale 1ns/1ps

module execute_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                enable,
   input  cpu_pkg::word_t      ex_op_a,
   input  cpu_pkg::word_t      ex_op_b,
   input  cpu_pkg::word_t      ex_imm,
   input  cpu_pkg::alu_ctrl_t  ex_alu_ctrl,
   input  cpu_pkg::reg_addr_t  ex_rs,
   input  cpu_pkg::reg_addr_t  ex_rt,
   input  cpu_pkg::reg_addr_t  ex_dest,
   input  logic                ex_alu_src,
   input  logic                ex_reg_write,
   input  logic                ex_mem_read,
   input  logic                ex_mem_write,
   input  logic                ex_mem_to_reg,
   input  logic                wb_write,
   input  cpu_pkg::reg_addr_t  wb_addr,
   input  cpu_pkg::word_t      wb_data,
   output cpu_pkg::word_t      mem_result,
   output cpu_pkg::word_t      mem_store,
   output cpu_pkg::reg_addr_t  mem_dest,
   output logic                mem_reg_write,
   output logic                mem_mem_read,
   output logic                mem_mem_write,
   output logic                mem_mem_to_reg
);

   cpu_pkg::word_t  fwd_a;
   cpu_pkg::word_t  fwd_b;
   cpu_pkg::word_t  alu_b;
   cpu_pkg::word_t  alu_out;

   // EX/MEM wins over MEM/WB, r0 never forwards
   always_comb begin
      fwd_a = ex_op_a;
      fwd_b = ex_op_b;
      if (mem_reg_write && (mem_dest != '0) && (mem_dest == ex_rs)) begin
         fwd_a = mem_result;
      end else if (wb_write && (wb_addr != '0) && (wb_addr == ex_rs)) begin
         fwd_a = wb_data;
      end
      if (mem_reg_write && (mem_dest != '0) && (mem_dest == ex_rt)) begin
         fwd_b = mem_result;
      end else if (wb_write && (wb_addr != '0) && (wb_addr == ex_rt)) begin
         fwd_b = wb_data;
      end
   end

   assign alu_b = ex_alu_src ? ex_imm : fwd_b;

   always_comb begin
      case (ex_alu_ctrl)
         cpu_pkg::ALU_ADD: alu_out = fwd_a + alu_b;
         cpu_pkg::ALU_SUB: alu_out = fwd_a - alu_b;
         cpu_pkg::ALU_AND: alu_out = fwd_a & alu_b;
         cpu_pkg::ALU_OR:  alu_out = fwd_a | alu_b;
         // signed compare
         cpu_pkg::ALU_SLT: alu_out = ($signed(fwd_a) < $signed(alu_b)) ? 1 : '0;
         default:          alu_out = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_result     <= '0;
         mem_store      <= '0;
         mem_dest       <= '0;
         mem_reg_write  <= 1'b0;
         mem_mem_read   <= 1'b0;
         mem_mem_write  <= 1'b0;
         mem_mem_to_reg <= 1'b0;
      end else if (enable) begin
         mem_result     <= alu_out;
         mem_store      <= fwd_b;
         mem_dest       <= ex_dest;
         mem_reg_write  <= ex_reg_write;
         mem_mem_read   <= ex_mem_read;
         mem_mem_write  <= ex_mem_write;
         mem_mem_to_reg <= ex_mem_to_reg;
      end
   end

endmodule

/* memory_stage.sv */
/*
 * memory stage: data memory with an external port, the MEM/WB
 * register and the writeback select
 */
`timescale 1ns/1ps
`include "cpu_config.svh"

module memory_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                enable,
   input  cpu_pkg::word_t      mem_result,
   input  cpu_pkg::word_t      mem_store,
   input  cpu_pkg::reg_addr_t  mem_dest,
   input  logic                mem_reg_write,
   input  logic                mem_mem_read,
   input  logic                mem_mem_write,
   input  logic                mem_mem_to_reg,
   output logic                wb_write,
   output cpu_pkg::reg_addr_t  wb_addr,
   output cpu_pkg::word_t      wb_data,
   input  cpu_pkg::word_t      addr_ext_2,
   input  logic                wen_ext_2,
   input  logic                ren_ext_2,
   input  cpu_pkg::word_t      wdata_ext_2,
   output cpu_pkg::word_t      rdata_ext_2
);

   cpu_pkg::word_t               dmem [0:(1 << `CPU_DMEM_ADDR_W) - 1];
   logic [`CPU_DMEM_ADDR_W-1:0]  core_idx;
   logic [`CPU_DMEM_ADDR_W-1:0]  ext_idx;
   cpu_pkg::word_t               load_data;
   cpu_pkg::word_t               wb_load;
   cpu_pkg::word_t               wb_result;
   logic                         wb_reg_write;
   logic                         wb_mem_to_reg;

   assign core_idx  = mem_result[`CPU_DMEM_ADDR_W+1:2];
   assign ext_idx   = addr_ext_2[`CPU_DMEM_ADDR_W+1:2];
   assign load_data = mem_mem_read ? dmem[core_idx] : '0;

   always_ff @(posedge clk) begin
      if (enable && mem_mem_write) begin
         dmem[core_idx] <= mem_store;
      end
      if (wen_ext_2) begin
         dmem[ext_idx] <= wdata_ext_2;
      end
      if (ren_ext_2) begin
         rdata_ext_2 <= dmem[ext_idx];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_load       <= '0;
         wb_result     <= '0;
         wb_addr       <= '0;
         wb_reg_write  <= 1'b0;
         wb_mem_to_reg <= 1'b0;
      end else if (enable) begin
         wb_load       <= load_data;
         wb_result     <= mem_result;
         wb_addr       <= mem_dest;
         wb_reg_write  <= mem_reg_write;
         wb_mem_to_reg <= mem_mem_to_reg;
      end
   end

   assign wb_data  = wb_mem_to_reg ? wb_load : wb_result;
   // no register write while the pipeline is frozen
   assign wb_write = wb_reg_write & enable;

endmodule

/* cpu.sv */
/*
 * cpu top: five-stage pipeline of fetch, decode, execute,
 * memory and writeback around a shared register file
 */
`timescale 1ns/1ps

module cpu (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           enable,
   input  cpu_pkg::word_t addr_ext,
   input  logic           wen_ext,
   input  logic           ren_ext,
   input  cpu_pkg::word_t wdata_ext,
   output cpu_pkg::word_t rdata_ext,
   input  cpu_pkg::word_t addr_ext_2,
   input  logic           wen_ext_2,
   input  logic           ren_ext_2,
   input  cpu_pkg::word_t wdata_ext_2,
   output cpu_pkg::word_t rdata_ext_2
);

   cpu_pkg::word_t      instr;
   logic                stall;
   cpu_pkg::reg_addr_t  raddr_1;
   cpu_pkg::reg_addr_t  raddr_2;
   cpu_pkg::word_t      rdata_1;
   cpu_pkg::word_t      rdata_2;
   cpu_pkg::word_t      ex_op_a;
   cpu_pkg::word_t      ex_op_b;
   cpu_pkg::word_t      ex_imm;
   cpu_pkg::alu_ctrl_t  ex_alu_ctrl;
   cpu_pkg::reg_addr_t  ex_rs;
   cpu_pkg::reg_addr_t  ex_rt;
   cpu_pkg::reg_addr_t  ex_dest;
   logic                ex_alu_src;
   logic                ex_reg_write;
   logic                ex_mem_read;
   logic                ex_mem_write;
   logic                ex_mem_to_reg;
   cpu_pkg::word_t      mem_result;
   cpu_pkg::word_t      mem_store;
   cpu_pkg::reg_addr_t  mem_dest;
   logic                mem_reg_write;
   logic                mem_mem_read;
   logic                mem_mem_write;
   logic                mem_mem_to_reg;
   logic                wb_write;
   cpu_pkg::reg_addr_t  wb_addr;
   cpu_pkg::word_t      wb_data;

   fetch_stage i_fetch (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .stall     (stall),
      .instr     (instr),
      .addr_ext  (addr_ext),
      .wen_ext   (wen_ext),
      .ren_ext   (ren_ext),
      .wdata_ext (wdata_ext),
      .rdata_ext (rdata_ext)
   );

   decode_stage i_decode (
      .clk           (clk),
      .arst_n        (arst_n),
      .enable        (enable),
      .instr         (instr),
      .rdata_1       (rdata_1),
      .rdata_2       (rdata_2),
      .raddr_1       (raddr_1),
      .raddr_2       (raddr_2),
      .stall         (stall),
      .ex_op_a       (ex_op_a),
      .ex_op_b       (ex_op_b),
      .ex_imm        (ex_imm),
      .ex_alu_ctrl   (ex_alu_ctrl),
      .ex_rs         (ex_rs),
      .ex_rt         (ex_rt),
      .ex_dest       (ex_dest),
      .ex_alu_src    (ex_alu_src),
      .ex_reg_write  (ex_reg_write),
      .ex_mem_read   (ex_mem_read),
      .ex_mem_write  (ex_mem_write),
      .ex_mem_to_reg (ex_mem_to_reg)
   );

   register_file i_regfile (
      .clk      (clk),
      .arst_n   (arst_n),
      .raddr_1  (raddr_1),
      .raddr_2  (raddr_2),
      .rdata_1  (rdata_1),
      .rdata_2  (rdata_2),
      .wb_write (wb_write),
      .wb_addr  (wb_addr),
      .wb_data  (wb_data)
   );

   execute_stage i_execute (
      .clk            (clk),
      .arst_n         (arst_n),
      .enable         (enable),
      .ex_op_a        (ex_op_a),
      .ex_op_b        (ex_op_b),
      .ex_imm         (ex_imm),
      .ex_alu_ctrl    (ex_alu_ctrl),
      .ex_rs          (ex_rs),
      .ex_rt          (ex_rt),
      .ex_dest        (ex_dest),
      .ex_alu_src     (ex_alu_src),
      .ex_reg_write   (ex_reg_write),
      .ex_mem_read    (ex_mem_read),
      .ex_mem_write   (ex_mem_write),
      .ex_mem_to_reg  (ex_mem_to_reg),
      .wb_write       (wb_write),
      .wb_addr        (wb_addr),
      .wb_data        (wb_data),
      .mem_result     (mem_result),
      .mem_store      (mem_store),
      .mem_dest       (mem_dest),
      .mem_reg_write  (mem_reg_write),
      .mem_mem_read   (mem_mem_read),
      .mem_mem_write  (mem_mem_write),
      .mem_mem_to_reg (mem_mem_to_reg)
   );

   memory_stage i_memory (
      .clk            (clk),
      .arst_n         (arst_n),
      .enable         (enable),
      .mem_result     (mem_result),
      .mem_store      (mem_store),
      .mem_dest       (mem_dest),
      .mem_reg_write  (mem_reg_write),
      .mem_mem_read   (mem_mem_read),
      .mem_mem_write  (mem_mem_write),
      .mem_mem_to_reg (mem_mem_to_reg),
      .wb_write       (wb_write),
      .wb_addr        (wb_addr),
      .wb_data        (wb_data),
      .addr_ext_2     (addr_ext_2),
      .wen_ext_2      (wen_ext_2),
      .ren_ext_2      (ren_ext_2),
      .wdata_ext_2    (wdata_ext_2),
      .rdata_ext_2    (rdata_ext_2)
   );

endmodule

/* cpu_properties.sv */
/*
 * bound checks on the cpu: single-cycle load-use stall, no data
 * memory store while the pipeline is frozen, no stall out of reset
 */
`timescale 1ns/1ps

module cpu_properties (
   input logic           clk,
   input logic           arst_n,
   input logic           enable,
   input logic           stall,
   input logic           wen_ext_2,
   input logic           mem_mem_write,
   input cpu_pkg::word_t store_target
);

   int unsigned assert_errors = 0;

   // a load-use stall lasts one enabled cycle
   stall_single: assert property (@(posedge clk) disable iff (!arst_n)
      (enable && stall) |=> !(enable && stall))
      else begin
         $error("stall high on two consecutive enabled cycles");
         assert_errors++;
      end

   // a store parked in EX/MEM leaves its memory word alone while frozen
   no_store_frozen: assert property (@(posedge clk) disable iff (!arst_n)
      (!enable && mem_mem_write && !wen_ext_2) |=> $stable(store_target))
      else begin
         $error("data memory written by the core while enable was low");
         assert_errors++;
      end

   // pipeline comes out of reset full of nops
   no_stall_after_reset: assert property (@(posedge clk)
      $rose(arst_n) |-> !stall)
      else begin
         $error("stall high in the first cycle after reset release");
         assert_errors++;
      end

endmodule

bind cpu cpu_properties i_props (
   .clk           (clk),
   .arst_n        (arst_n),
   .enable        (enable),
   .stall         (stall),
   .wen_ext_2     (wen_ext_2),
   .mem_mem_write (mem_mem_write),
   .store_target  (i_memory.dmem[i_memory.core_idx])
);

/* tb_clock_gen.sv */
/*
 * testbench clock and reset generator: free-running clock and
 * an active-low reset held for a number of cycles
 */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release just after a rising edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;
   end

endmodule

/* tb_cpu.sv */
/*
 * cpu testbench: loads a program and data through the external
 * ports, runs it with a freeze, and checks memory against a model
 */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;

   localparam int PROG_LEN      = 39;
   localparam int PROG_N        = PROG_LEN + 12;
   localparam int DATA_N        = 32;
   localparam int CHECK_N       = 23;
   localparam int FREEZE_AT     = 11;
   localparam int FREEZE_LEN    = 6;
   localparam int DRIVE_DELAY   = 5;
   localparam int RESET_TIMEOUT = 20;

   logic           clk;
   logic           arst_n;
   logic           enable;
   cpu_pkg::word_t addr_ext;
   logic           wen_ext;
   logic           ren_ext;
   cpu_pkg::word_t wdata_ext;
   cpu_pkg::word_t rdata_ext;
   cpu_pkg::word_t addr_ext_2;
   logic           wen_ext_2;
   logic           ren_ext_2;
   cpu_pkg::word_t wdata_ext_2;
   cpu_pkg::word_t rdata_ext_2;

   cpu_pkg::word_t prog [PROG_N];
   cpu_pkg::word_t init_data [DATA_N];
   cpu_pkg::word_t check_exp [CHECK_N];
   cpu_pkg::word_t check_addr [CHECK_N] = '{
      32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c,
      32'h40, 32'h44, 32'h48, 32'h4c, 32'h50, 32'h54, 32'h58, 32'h5c,
      32'h60, 32'h64, 32'h68, 32'h6c, 32'h70, 32'h74, 32'h78
   };
   cpu_pkg::word_t ref_regs [32];
   cpu_pkg::word_t ref_mem [0:(1 << `CPU_DMEM_ADDR_W) - 1];

   integer seed;
   int     errors;
   int     checks;
   int     exp_stalls;
   int     stalls_seen;

   tb_clock_gen #(
      .PERIOD_NS    (100),
      .RESET_CYCLES (5)
   ) i_clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   cpu i_dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .enable      (enable),
      .addr_ext    (addr_ext),
      .wen_ext     (wen_ext),
      .ren_ext     (ren_ext),
      .wdata_ext   (wdata_ext),
      .rdata_ext   (rdata_ext),
      .addr_ext_2  (addr_ext_2),
      .wen_ext_2   (wen_ext_2),
      .ren_ext_2   (ren_ext_2),
      .wdata_ext_2 (wdata_ext_2),
      .rdata_ext_2 (rdata_ext_2)
   );

   // enabled cycles spent in a load-use stall
   always @(negedge clk) begin
      if (arst_n === 1'b1 && enable === 1'b1 && i_dut.stall === 1'b1) begin
         stalls_seen++;
      end
   end

   function automatic cpu_pkg::word_t rtype_word(input cpu_pkg::funct_t fn,
                                                 input int rd, input int rs, input int rt);
      return {`CPU_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic cpu_pkg::word_t itype_word(input cpu_pkg::opcode_t op,
                                                 input int rt, input int rs, input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   task automatic build_program();
      prog[0]  = itype_word(`CPU_OP_ADDI, 1, 0, 5);
      prog[1]  = itype_word(`CPU_OP_ADDI, 2, 0, -3);
      // distances 1 and 2
      prog[2]  = rtype_word(`CPU_FN_ADD, 3, 1, 2);
      prog[3]  = rtype_word(`CPU_FN_SUB, 4, 3, 1);
      prog[4]  = rtype_word(`CPU_FN_AND, 5, 4, 1);
      prog[5]  = rtype_word(`CPU_FN_OR,  6, 5, 2);
      prog[6]  = rtype_word(`CPU_FN_SLT, 7, 2, 1);
      prog[7]  = rtype_word(`CPU_FN_SLT, 8, 1, 2);
      prog[8]  = itype_word(`CPU_OP_SW, 3, 0, 64);
      prog[9]  = itype_word(`CPU_OP_SW, 4, 0, 68);
      prog[10] = itype_word(`CPU_OP_SW, 5, 0, 72);
      prog[11] = itype_word(`CPU_OP_SW, 6, 0, 76);
      prog[12] = itype_word(`CPU_OP_SW, 7, 0, 80);
      prog[13] = itype_word(`CPU_OP_SW, 8, 0, 84);
      // load-use into an alu operand, then into store data
      prog[14] = itype_word(`CPU_OP_LW, 9, 0, 0);
      prog[15] = rtype_word(`CPU_FN_ADD, 10, 9, 1);
      prog[16] = itype_word(`CPU_OP_SW, 10, 0, 88);
      prog[17] = itype_word(`CPU_OP_LW, 11, 0, 4);
      prog[18] = itype_word(`CPU_OP_SW, 11, 0, 92);
      // r0 write is discarded
      prog[19] = itype_word(`CPU_OP_ADDI, 0, 1, 7);
      prog[20] = itype_word(`CPU_OP_SW, 0, 0, 96);
      prog[21] = itype_word(`CPU_OP_LW, 12, 0, 8);
      prog[22] = '0;
      prog[23] = rtype_word(`CPU_FN_SUB, 13, 12, 9);
      prog[24] = itype_word(`CPU_OP_SW, 13, 0, 100);
      prog[25] = itype_word(`CPU_OP_ADDI, 14, 0, -100);
      prog[26] = itype_word(`CPU_OP_ADDI, 15, 14, 30);
      prog[27] = rtype_word(`CPU_FN_SLT, 16, 15, 14);
      prog[28] = rtype_word(`CPU_FN_SLT, 17, 14, 15);
      prog[29] = itype_word(`CPU_OP_SW, 15, 0, 104);
      prog[30] = itype_word(`CPU_OP_SW, 16, 0, 108);
      prog[31] = itype_word(`CPU_OP_SW, 17, 0, 112);
      prog[32] = itype_word(`CPU_OP_LW, 18, 0, 12);
      prog[33] = itype_word(`CPU_OP_LW, 19, 0, 16);
      prog[34] = rtype_word(`CPU_FN_AND, 20, 18, 19);
      prog[35] = rtype_word(`CPU_FN_OR,  21, 20, 18);
      prog[36] = itype_word(`CPU_OP_SW, 21, 0, 116);
      prog[37] = itype_word(`CPU_OP_SW, 20, 0, 120);
      prog[38] = itype_word(`CPU_OP_SW, 1, 0, 20);
      for (int i = PROG_LEN; i < PROG_N; i++) begin
         prog[i] = '0;
      end
   endtask

   // one instruction at a time, in program order
   task automatic run_reference();
      cpu_pkg::opcode_t op;
      cpu_pkg::funct_t  fn;
      cpu_pkg::word_t   a;
      cpu_pkg::word_t   b;
      cpu_pkg::word_t   imm;
      cpu_pkg::word_t   addr;
      logic [4:0]       rs;
      logic [4:0]       rt;
      logic [4:0]       rd;
      for (int r = 0; r < 32; r++) begin
         ref_regs[r] = '0;
      end
      for (int i = 0; i < DATA_N; i++) begin
         ref_mem[i] = init_data[i];
      end
      for (int i = 0; i < PROG_N; i++) begin
         op   = prog[i][31:26];
         rs   = prog[i][25:21];
         rt   = prog[i][20:16];
         rd   = prog[i][15:11];
         fn   = prog[i][5:0];
         a    = ref_regs[rs];
         b    = ref_regs[rt];
         imm  = {{16{prog[i][15]}}, prog[i][15:0]};
         addr = a + imm;
         case (op)
            `CPU_OP_RTYPE: begin
               case (fn)
                  `CPU_FN_ADD: ref_regs[rd] = a + b;
                  `CPU_FN_SUB: ref_regs[rd] = a - b;
                  `CPU_FN_AND: ref_regs[rd] = a & b;
                  `CPU_FN_OR:  ref_regs[rd] = a | b;
                  `CPU_FN_SLT: ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: ;
               endcase
            end
            `CPU_OP_ADDI: ref_regs[rt] = addr;
            `CPU_OP_LW:   ref_regs[rt] = ref_mem[addr[`CPU_DMEM_ADDR_W+1:2]];
            `CPU_OP_SW:   ref_mem[addr[`CPU_DMEM_ADDR_W+1:2]] = b;
            default: ;
         endcase
         ref_regs[0] = '0;
      end
   endtask

   // a load followed by an instruction naming its target as rs or rt
   function automatic int count_stalls();
      int n;
      n = 0;
      for (int i = 0; i < PROG_N - 1; i++) begin
         if (prog[i][31:26] == `CPU_OP_LW &&
             (prog[i][20:16] == prog[i+1][25:21] || prog[i][20:16] == prog[i+1][20:16])) begin
            n++;
         end
      end
      return n;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      while (arst_n !== 1'b1 && n < RESET_TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (arst_n !== 1'b1) begin
         $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
         errors++;
      end
      next_cycle();
   endtask

   task automatic load_memories();
      for (int i = 0; i < PROG_N; i++) begin
         addr_ext  = i * 4;
         wdata_ext = prog[i];
         wen_ext   = 1'b1;
         next_cycle();
      end
      wen_ext = 1'b0;
      for (int i = 0; i < DATA_N; i++) begin
         addr_ext_2  = i * 4;
         wdata_ext_2 = init_data[i];
         wen_ext_2   = 1'b1;
         next_cycle();
      end
      wen_ext_2 = 1'b0;
   endtask

   task automatic readback_program();
      for (int i = 0; i < PROG_N; i++) begin
         addr_ext = i * 4;
         ren_ext  = 1'b1;
         next_cycle();
         ren_ext = 1'b0;
         checks++;
         if (rdata_ext !== prog[i]) begin
            $display("FAIL rdata_ext addr %h: got %h expected %h", addr_ext, rdata_ext, prog[i]);
            errors++;
         end
      end
   endtask

   task automatic run_program();
      int total;
      total  = PROG_LEN + exp_stalls + 8;
      enable = 1'b1;
      for (int n = 0; n < total; n++) begin
         if (n == FREEZE_AT) begin
            enable = 1'b0;
            repeat (FREEZE_LEN) next_cycle();
            enable = 1'b1;
         end
         next_cycle();
      end
      enable = 1'b0;
   endtask

   task automatic check_data();
      for (int i = 0; i < CHECK_N; i++) begin
         addr_ext_2 = check_addr[i];
         ren_ext_2  = 1'b1;
         next_cycle();
         ren_ext_2 = 1'b0;
         checks++;
         if (rdata_ext_2 !== check_exp[i]) begin
            $display("FAIL rdata_ext_2 addr %h: got %h expected %h",
                     check_addr[i], rdata_ext_2, check_exp[i]);
            errors++;
         end
      end
   endtask

   initial begin
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      ren_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      errors      = 0;
      checks      = 0;
      stalls_seen = 0;
      seed        = 32'h59ab5ed3;

      build_program();
      for (int i = 0; i < DATA_N; i++) begin
         init_data[i] = $random(seed);
      end
      run_reference();
      for (int i = 0; i < CHECK_N; i++) begin
         check_exp[i] = ref_mem[check_addr[i][`CPU_DMEM_ADDR_W+1:2]];
      end
      exp_stalls = count_stalls();

      wait_reset();
      load_memories();
      readback_program();
      run_program();
      check_data();

      checks++;
      if (stalls_seen != exp_stalls) begin
         $display("FAIL stall count: got %h expected %h", stalls_seen, exp_stalls);
         errors++;
      end
      if (i_dut.i_props.assert_errors != 0) begin
         $display("bound assertions failed %0d times", i_dut.i_props.assert_errors);
         errors += i_dut.i_props.assert_errors;
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_properties.sv
tb_clock_gen.sv
tb_cpu.sv
